//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// ==============================
	// Widths and latencies
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int TAG_W = 4;
	localparam int MUL_LATENCY = 2;
	localparam int MUL_COUNT_W = $clog2(MUL_LATENCY + 1);
	localparam int DIV_COUNT_W = $clog2(XLEN);

	// ==============================
	// Instruction encodings
	typedef enum logic [2:0] {
		CLASS_ARITH   = 3'd0,
		CLASS_SHIFT   = 3'd1,
		CLASS_COMPARE = 3'd2,
		CLASS_JUMP    = 3'd3,
		CLASS_BRANCH  = 3'd4,
		CLASS_MULDIV  = 3'd5
	} inst_class_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLL  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_EQ   = 4'd8,
		ALU_NE   = 4'd9,
		ALU_LT   = 4'd10,
		ALU_LTU  = 4'd11,
		ALU_GE   = 4'd12,
		ALU_GEU  = 4'd13
	} alu_op_e;

	typedef enum logic [2:0] {
		OP_MUL   = 3'd0,
		OP_MULH  = 3'd1,
		OP_MULHU = 3'd2,
		OP_DIV   = 3'd3,
		OP_DIVU  = 3'd4,
		OP_REM   = 3'd5,
		OP_REMU  = 3'd6
	} muldiv_op_e;

	typedef enum logic [2:0] {
		SEL_ZERO = 3'd0,
		SEL_RS1  = 3'd1,
		SEL_RS2  = 3'd2,
		SEL_PC   = 3'd3,
		SEL_IMM  = 3'd4
	} operand_sel_e;

endpackage

`default_nettype wire

//--- cpu_alu.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_alu (
	input  wire cpu_pkg::alu_op_e        i_op,
	input  wire [cpu_pkg::XLEN-1:0]      i_op1,
	input  wire [cpu_pkg::XLEN-1:0]      i_op2,
	output logic [cpu_pkg::XLEN-1:0]     o_result,
	output logic [cpu_pkg::XLEN-1:0]     o_shift_result,
	output logic                         o_compare_result
);

	import cpu_pkg::*;

	logic [4:0] shamt;

	assign shamt = i_op2[4:0];

	// Arithmetic and logic
	always_comb begin
		case (i_op)
			ALU_SUB: o_result = i_op1 - i_op2;
			ALU_AND: o_result = i_op1 & i_op2;
			ALU_OR:  o_result = i_op1 | i_op2;
			ALU_XOR: o_result = i_op1 ^ i_op2;
			default: o_result = i_op1 + i_op2;
		endcase
	end

	always_comb begin
		case (i_op)
			ALU_SRL: o_shift_result = i_op1 >> shamt;
			ALU_SRA: o_shift_result = XLEN'($signed(i_op1) >>> shamt);
			default: o_shift_result = i_op1 << shamt;
		endcase
	end

	// Signedness picked by the op
	always_comb begin
		case (i_op)
			ALU_EQ:  o_compare_result = (i_op1 == i_op2);
			ALU_NE:  o_compare_result = (i_op1 != i_op2);
			ALU_LT:  o_compare_result = ($signed(i_op1) < $signed(i_op2));
			ALU_LTU: o_compare_result = (i_op1 < i_op2);
			ALU_GE:  o_compare_result = ($signed(i_op1) >= $signed(i_op2));
			ALU_GEU: o_compare_result = (i_op1 >= i_op2);
			default: o_compare_result = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- cpu_multiply.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_multiply (
	input  wire                          i_clock,
	input  wire                          i_signed_a,
	input  wire                          i_signed_b,
	input  wire [cpu_pkg::XLEN-1:0]      i_op1,
	input  wire [cpu_pkg::XLEN-1:0]      i_op2,
	output logic [2*cpu_pkg::XLEN-1:0]   o_result
);

	import cpu_pkg::*;

	logic signed [XLEN:0] op_a_q;
	logic signed [XLEN:0] op_b_q;
	logic [2*XLEN-1:0] product_q;

	// Stage one, operands with one extra sign bit
	always_ff @(posedge i_clock) begin
		op_a_q <= {i_signed_a & i_op1[XLEN-1], i_op1};
		op_b_q <= {i_signed_b & i_op2[XLEN-1], i_op2};
	end

	// Stage two, low 64 bits of the 33x33 product
	always_ff @(posedge i_clock) begin
		product_q <= (2*XLEN)'(op_a_q * op_b_q);
	end

	assign o_result = product_q;

endmodule

`default_nettype wire

//--- cpu_divide.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_divide (
	input  wire                          i_clock,
	input  wire                          i_reset,
	input  wire                          i_start,
	input  wire                          i_signed,
	input  wire [cpu_pkg::XLEN-1:0]      i_numerator,
	input  wire [cpu_pkg::XLEN-1:0]      i_denominator,
	output logic                         o_done,
	output logic [cpu_pkg::XLEN-1:0]     o_quotient,
	output logic [cpu_pkg::XLEN-1:0]     o_remainder
);

	import cpu_pkg::*;

	logic busy;
	logic [DIV_COUNT_W-1:0] count;
	logic [XLEN-1:0] quot;
	logic [XLEN-1:0] rem;
	logic [XLEN-1:0] den;
	logic [XLEN-1:0] num_q;
	logic neg_q;
	logic neg_r;
	logic den_zero;
	logic num_neg;
	logic den_neg;
	logic [XLEN:0] shifted;
	logic [XLEN:0] diff;

	assign num_neg = i_signed && i_numerator[XLEN-1];
	assign den_neg = i_signed && i_denominator[XLEN-1];

	// One restoring step
	assign shifted = {rem, quot[XLEN-1]};
	assign diff = shifted - {1'b0, den};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			count <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (i_start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy) begin
				count <= count + 1'b1;
				if (count == DIV_COUNT_W'(XLEN - 1)) begin
					busy <= 1'b0;
					o_done <= 1'b1;
				end
			end
		end
	end

	// Magnitudes loaded at start
	always_ff @(posedge i_clock) begin
		if (i_start) begin
			quot <= num_neg ? -i_numerator : i_numerator;
			den <= den_neg ? -i_denominator : i_denominator;
			rem <= '0;
			num_q <= i_numerator;
			neg_q <= num_neg ^ den_neg;
			neg_r <= num_neg;
			den_zero <= (i_denominator == '0);
		end else if (busy) begin
			if (!diff[XLEN]) begin
				rem <= diff[XLEN-1:0];
				quot <= {quot[XLEN-2:0], 1'b1};
			end else begin
				rem <= shifted[XLEN-1:0];
				quot <= {quot[XLEN-2:0], 1'b0};
			end
		end
	end

	// Most negative by -1 wraps back to the numerator on its own
	assign o_quotient = den_zero ? '1 : (neg_q ? -quot : quot);
	assign o_remainder = den_zero ? num_q : (neg_r ? -rem : rem);

endmodule

`default_nettype wire

//--- cpu_register_file.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_register_file (
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rs1_index,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rs2_index,
	output logic [cpu_pkg::XLEN-1:0]         o_rs1_data,
	output logic [cpu_pkg::XLEN-1:0]         o_rs2_data,
	input  wire                              i_write,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rd_index,
	input  wire [cpu_pkg::XLEN-1:0]          i_rd_data
);

	import cpu_pkg::*;

	localparam int REG_COUNT = 2 ** REG_ADDR_W;

	// x0 has no storage
	logic [XLEN-1:0] regs [1:REG_COUNT-1];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 1; i < REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (i_write && i_rd_index != '0) begin
			regs[i_rd_index] <= i_rd_data;
		end
	end

	assign o_rs1_data = (i_rs1_index == '0) ? '0 : regs[i_rs1_index];
	assign o_rs2_data = (i_rs2_index == '0) ? '0 : regs[i_rs2_index];

endmodule

`default_nettype wire

//--- cpu_execute.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_execute (
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire [cpu_pkg::TAG_W-1:0]         i_tag,
	input  wire cpu_pkg::inst_class_e        i_class,
	input  wire cpu_pkg::alu_op_e            i_alu_op,
	input  wire cpu_pkg::muldiv_op_e         i_muldiv_op,
	input  wire cpu_pkg::operand_sel_e       i_op1_sel,
	input  wire cpu_pkg::operand_sel_e       i_op2_sel,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rd,
	input  wire [cpu_pkg::XLEN-1:0]          i_pc,
	input  wire [cpu_pkg::XLEN-1:0]          i_imm,
	input  wire [cpu_pkg::XLEN-1:0]          i_rs1_data,
	input  wire [cpu_pkg::XLEN-1:0]          i_rs2_data,
	input  wire                              i_hold,
	output logic                             o_busy,
	output logic                             o_rf_write,
	output logic [cpu_pkg::REG_ADDR_W-1:0]   o_rf_rd,
	output logic [cpu_pkg::XLEN-1:0]         o_rf_data,
	output logic [cpu_pkg::TAG_W-1:0]        o_tag,
	output logic [cpu_pkg::XLEN-1:0]         o_result,
	output logic [cpu_pkg::REG_ADDR_W-1:0]   o_rd,
	output logic                             o_jump,
	output logic [cpu_pkg::XLEN-1:0]         o_jump_pc,
	output logic                             o_fault
);

	import cpu_pkg::*;

	typedef enum logic [1:0] {IDLE, MUL_WAIT, DIV_WAIT} state_e;

	state_e state;
	logic [MUL_COUNT_W-1:0] mul_count;
	logic div_ready;
	logic accept, start, retire, wb_write, take_jump, fault_set;
	logic [XLEN-1:0] wb_value, jump_pc, op1, op2;
	logic [XLEN-1:0] alu_result, alu_shift_result;
	logic alu_compare_result;
	logic [2*XLEN-1:0] mul_result;
	logic is_div, div_signed, div_done;
	logic [XLEN-1:0] div_quotient, div_remainder;

	function automatic logic [XLEN-1:0] select_operand(operand_sel_e sel,
			logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2, logic [XLEN-1:0] pc,
			logic [XLEN-1:0] imm);
		case (sel)
			SEL_RS1: return rs1;
			SEL_RS2: return rs2;
			SEL_PC:  return pc;
			SEL_IMM: return imm;
			default: return '0;
		endcase
	endfunction

	assign op1 = select_operand(i_op1_sel, i_rs1_data, i_rs2_data, i_pc, i_imm);
	assign op2 = select_operand(i_op2_sel, i_rs1_data, i_rs2_data, i_pc, i_imm);

	// ==============================
	// Units
	cpu_alu u_alu (.i_op(i_alu_op), .i_op1(op1), .i_op2(op2), .o_result(alu_result),
		.o_shift_result(alu_shift_result), .o_compare_result(alu_compare_result));

	cpu_multiply u_multiply (.i_clock(i_clock), .i_signed_a(i_muldiv_op == OP_MULH),
		.i_signed_b(i_muldiv_op == OP_MULH), .i_op1(i_rs1_data), .i_op2(i_rs2_data),
		.o_result(mul_result));

	assign is_div = i_muldiv_op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
	assign div_signed = (i_muldiv_op == OP_DIV) || (i_muldiv_op == OP_REM);

	cpu_divide u_divide (.i_clock(i_clock), .i_reset(i_reset), .i_start(start && is_div),
		.i_signed(div_signed), .i_numerator(i_rs1_data), .i_denominator(i_rs2_data),
		.o_done(div_done), .o_quotient(div_quotient), .o_remainder(div_remainder));

	// ==============================
	// Accept and retire
	assign accept = (i_tag != o_tag) && !i_hold;
	assign o_busy = i_hold || (state != IDLE) || ((i_tag != o_tag) && i_class == CLASS_MULDIV);

	always_comb begin
		start = 1'b0;
		retire = 1'b0;
		wb_write = 1'b0;
		wb_value = alu_result;
		take_jump = 1'b0;
		jump_pc = i_pc + 32'd4;
		fault_set = 1'b0;
		case (state)
			IDLE: if (accept) begin
				retire = 1'b1;
				wb_write = 1'b1;
				case (i_class)
					CLASS_ARITH: wb_value = alu_result;
					CLASS_SHIFT: wb_value = alu_shift_result;
					CLASS_COMPARE: wb_value = {{(XLEN-1){1'b0}}, alu_compare_result};
					CLASS_JUMP: begin
						wb_value = i_pc + 32'd4;
						take_jump = 1'b1;
						jump_pc = alu_result;
					end
					CLASS_BRANCH: begin
						// Reports the compare, no register write
						wb_write = 1'b0;
						wb_value = {{(XLEN-1){1'b0}}, alu_compare_result};
						take_jump = 1'b1;
						if (alu_compare_result) jump_pc = i_pc + i_imm;
					end
					CLASS_MULDIV: begin
						retire = 1'b0;
						wb_write = 1'b0;
						start = 1'b1;
					end
					default: begin
						// Unknown class, dropped with a fault
						wb_write = 1'b0;
						fault_set = 1'b1;
					end
				endcase
			end
			MUL_WAIT: begin
				retire = !i_hold && mul_count == MUL_COUNT_W'(MUL_LATENCY);
				wb_write = retire;
				wb_value = (i_muldiv_op == OP_MUL) ? mul_result[XLEN-1:0] : mul_result[2*XLEN-1:XLEN];
			end
			default: begin
				retire = !i_hold && (div_done || div_ready);
				wb_write = retire;
				wb_value = (i_muldiv_op inside {OP_DIV, OP_DIVU}) ? div_quotient : div_remainder;
			end
		endcase
	end

	assign o_rf_write = retire && wb_write;
	assign o_rf_rd = i_rd;
	assign o_rf_data = wb_value;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			mul_count <= '0;
			div_ready <= 1'b0;
			o_tag <= '0;
			o_result <= '0;
			o_rd <= '0;
			o_jump <= 1'b0;
			o_jump_pc <= '0;
			o_fault <= 1'b0;
		end else begin
			o_jump <= retire && take_jump;
			if (fault_set) o_fault <= 1'b1;
			// Done may land while held
			if (div_done) div_ready <= 1'b1;
			if (start) begin
				state <= is_div ? DIV_WAIT : MUL_WAIT;
				mul_count <= MUL_COUNT_W'(1);
			end else if (state == MUL_WAIT && !i_hold && !retire) begin
				mul_count <= mul_count + 1'b1;
			end
			if (retire) begin
				state <= IDLE;
				div_ready <= 1'b0;
				o_tag <= i_tag;
				o_result <= wb_value;
				o_rd <= i_rd;
				if (take_jump) o_jump_pc <= jump_pc;
			end
		end
	end

endmodule

`default_nettype wire

//--- cpu_execute_unit.sv
`default_nettype none
`timescale 1ns/10ps

module cpu_execute_unit (
	input  wire                              i_clock,
	input  wire                              i_reset,
	input  wire [cpu_pkg::TAG_W-1:0]         i_tag,
	input  wire cpu_pkg::inst_class_e        i_class,
	input  wire cpu_pkg::alu_op_e            i_alu_op,
	input  wire cpu_pkg::muldiv_op_e         i_muldiv_op,
	input  wire cpu_pkg::operand_sel_e       i_op1_sel,
	input  wire cpu_pkg::operand_sel_e       i_op2_sel,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rd,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rs1,
	input  wire [cpu_pkg::REG_ADDR_W-1:0]    i_rs2,
	input  wire [cpu_pkg::XLEN-1:0]          i_pc,
	input  wire [cpu_pkg::XLEN-1:0]          i_imm,
	input  wire                              i_hold,
	output logic                             o_busy,
	output logic [cpu_pkg::TAG_W-1:0]        o_tag,
	output logic [cpu_pkg::XLEN-1:0]         o_result,
	output logic [cpu_pkg::REG_ADDR_W-1:0]   o_rd,
	output logic                             o_jump,
	output logic [cpu_pkg::XLEN-1:0]         o_jump_pc,
	output logic                             o_fault
);

	import cpu_pkg::*;

	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic rf_write;
	logic [REG_ADDR_W-1:0] rf_rd;
	logic [XLEN-1:0] rf_data;

	cpu_register_file u_register_file (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1_index(i_rs1),
		.i_rs2_index(i_rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_write(rf_write),
		.i_rd_index(rf_rd),
		.i_rd_data(rf_data)
	);

	cpu_execute u_execute (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_tag(i_tag),
		.i_class(i_class),
		.i_alu_op(i_alu_op),
		.i_muldiv_op(i_muldiv_op),
		.i_op1_sel(i_op1_sel),
		.i_op2_sel(i_op2_sel),
		.i_rd(i_rd),
		.i_pc(i_pc),
		.i_imm(i_imm),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.i_hold(i_hold),
		.o_busy(o_busy),
		.o_rf_write(rf_write),
		.o_rf_rd(rf_rd),
		.o_rf_data(rf_data),
		.o_tag(o_tag),
		.o_result(o_result),
		.o_rd(o_rd),
		.o_jump(o_jump),
		.o_jump_pc(o_jump_pc),
		.o_fault(o_fault)
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		forever #(PERIOD_NS / 2) o_clock = ~o_clock;
	end

	// Released on a rising edge
	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_cpu_execute_unit.sv
`default_nettype none
`timescale 1ns/10ps

module tb_cpu_execute_unit;

	import cpu_pkg::*;

	localparam int CLOCK_NS = 8;
	localparam int N_RESET_READS = 8;
	localparam int N_FILL = 31;
	localparam int N_FLOW = 40;
	localparam int N_RANDOM = 200;
	localparam int N_MULDIV_PAIRS = 8;
	localparam int N_MULDIV = N_MULDIV_PAIRS * 9;
	localparam int N_HOLD = 24;
	localparam int N_INST = N_RESET_READS + N_FILL + N_FLOW + N_RANDOM + N_MULDIV + N_HOLD + 1;

	logic clock;
	logic reset;
	logic [TAG_W-1:0] tag = '0;
	inst_class_e inst_class = CLASS_ARITH;
	alu_op_e alu_op = ALU_ADD;
	muldiv_op_e muldiv_op = OP_MUL;
	operand_sel_e op1_sel = SEL_ZERO;
	operand_sel_e op2_sel = SEL_ZERO;
	logic [REG_ADDR_W-1:0] rd = '0;
	logic [REG_ADDR_W-1:0] rs1 = '0;
	logic [REG_ADDR_W-1:0] rs2 = '0;
	logic [XLEN-1:0] pc = '0;
	logic [XLEN-1:0] imm = '0;
	logic hold = 1'b0;

	logic busy;
	logic [TAG_W-1:0] ret_tag;
	logic [XLEN-1:0] result;
	logic [REG_ADDR_W-1:0] ret_rd;
	logic jump;
	logic [XLEN-1:0] jump_pc;
	logic fault;

	logic [XLEN-1:0] model_regs [0:31];
	logic [XLEN-1:0] exp_result;
	logic exp_write;
	logic exp_jump;
	logic [XLEN-1:0] exp_jump_pc;
	logic exp_fault;
	logic [REG_ADDR_W-1:0] exp_rd;
	logic [31:0] lfsr_state = 32'h517d_9ecc;
	event check_event;
	event done_event;

	tb_clock #(.PERIOD_NS(CLOCK_NS), .RESET_CYCLES(2)) u_clock (
		.o_clock(clock),
		.o_reset(reset)
	);

	cpu_execute_unit u_dut (
		.i_clock(clock),
		.i_reset(reset),
		.i_tag(tag),
		.i_class(inst_class),
		.i_alu_op(alu_op),
		.i_muldiv_op(muldiv_op),
		.i_op1_sel(op1_sel),
		.i_op2_sel(op2_sel),
		.i_rd(rd),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.i_pc(pc),
		.i_imm(imm),
		.i_hold(hold),
		.o_busy(busy),
		.o_tag(ret_tag),
		.o_result(result),
		.o_rd(ret_rd),
		.o_jump(jump),
		.o_jump_pc(jump_pc),
		.o_fault(fault)
	);

	// ==============================
	// Random source
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// ==============================
	// Reference model
	function automatic logic [31:0] pick(operand_sel_e sel, logic [31:0] a, logic [31:0] b,
			logic [31:0] pc_v, logic [31:0] imm_v);
		case (sel)
			SEL_RS1: return a;
			SEL_RS2: return b;
			SEL_PC: return pc_v;
			SEL_IMM: return imm_v;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic [31:0] muldiv_ref(muldiv_op_e op, logic [31:0] a, logic [31:0] b);
		logic signed [63:0] sprod;
		logic [63:0] uprod;
		logic overflow;
		sprod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		uprod = {32'd0, a} * {32'd0, b};
		overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		case (op)
			OP_MUL: return uprod[31:0];
			OP_MULH: return sprod[63:32];
			OP_MULHU: return uprod[63:32];
			OP_DIV: begin
				if (b == 0)
					return 32'hffff_ffff;
				if (overflow)
					return a;
				return $signed(a) / $signed(b);
			end
			OP_DIVU: return (b == 0) ? 32'hffff_ffff : a / b;
			OP_REM: begin
				if (b == 0)
					return a;
				if (overflow)
					return 32'd0;
				return $signed(a) % $signed(b);
			end
			default: return (b == 0) ? a : a % b;
		endcase
	endfunction

	function automatic void reference(input inst_class_e cls, input alu_op_e aop,
			input muldiv_op_e mop, input operand_sel_e sel1, input operand_sel_e sel2,
			input logic [31:0] a, input logic [31:0] b, input logic [31:0] pc_v,
			input logic [31:0] imm_v, output logic [31:0] res, output logic wr,
			output logic jmp, output logic [31:0] target, output logic flt);
		logic [31:0] x;
		logic [31:0] y;
		logic cond;
		x = pick(sel1, a, b, pc_v, imm_v);
		y = pick(sel2, a, b, pc_v, imm_v);
		res = 32'd0;
		wr = 1'b1;
		jmp = 1'b0;
		target = pc_v + 32'd4;
		flt = 1'b0;
		case (aop)
			ALU_EQ: cond = (x == y);
			ALU_NE: cond = (x != y);
			ALU_LT: cond = ($signed(x) < $signed(y));
			ALU_LTU: cond = (x < y);
			ALU_GE: cond = ($signed(x) >= $signed(y));
			ALU_GEU: cond = (x >= y);
			default: cond = 1'b0;
		endcase
		case (cls)
			CLASS_ARITH: begin
				case (aop)
					ALU_SUB: res = x - y;
					ALU_AND: res = x & y;
					ALU_OR: res = x | y;
					ALU_XOR: res = x ^ y;
					default: res = x + y;
				endcase
			end
			CLASS_SHIFT: begin
				case (aop)
					ALU_SRL: res = x >> y[4:0];
					ALU_SRA: res = $signed(x) >>> y[4:0];
					default: res = x << y[4:0];
				endcase
			end
			CLASS_COMPARE: res = {31'd0, cond};
			CLASS_JUMP: begin
				res = pc_v + 32'd4;
				jmp = 1'b1;
				target = x + y;
			end
			CLASS_BRANCH: begin
				res = {31'd0, cond};
				wr = 1'b0;
				jmp = 1'b1;
				if (cond)
					target = pc_v + imm_v;
			end
			CLASS_MULDIV: res = muldiv_ref(mop, a, b);
			default: begin
				wr = 1'b0;
				flt = 1'b1;
			end
		endcase
	endfunction

	task automatic report_error(input string msg);
		$display("FAIL at %0t ns: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first error");
	endtask

	// ==============================
	// Driver
	task automatic issue(input int hold_start, input int hold_len);
		int cycles;
		logic [TAG_W-1:0] prev_tag;
		logic was_held;
		logic retired;
		reference(inst_class, alu_op, muldiv_op, op1_sel, op2_sel, model_regs[rs1],
			model_regs[rs2], pc, imm, exp_result, exp_write, exp_jump, exp_jump_pc, exp_fault);
		exp_rd = rd;
		tag = tag + 1'b1;
		hold = (hold_start == 0) && (hold_len > 0);
		cycles = 0;
		retired = 1'b0;
		while (!retired) begin
			prev_tag = ret_tag;
			was_held = hold;
			@(negedge clock);
			cycles++;
			if (was_held) begin
				assert (ret_tag == prev_tag) else report_error("o_tag changed while held");
			end
			retired = (ret_tag == tag);
			if (!retired) begin
				if (hold || inst_class == CLASS_MULDIV) begin
					assert (busy) else report_error("o_busy low with an instruction pending");
				end
				hold = (cycles >= hold_start) && (cycles < hold_start + hold_len);
			end
		end
		if (inst_class != CLASS_MULDIV) begin
			assert (cycles == hold_len + 1)
			else report_error($sformatf("retired after %0d cycles, expected %0d",
				cycles, hold_len + 1));
		end
		->check_event;
		@(done_event);
		if (exp_write && rd != 0)
			model_regs[rd] = exp_result;
		@(negedge clock);
		assert (!jump) else report_error("o_jump high for more than one cycle");
	endtask

	task automatic random_regs();
		rd = rand_bits(5);
		rs1 = rand_bits(5);
		rs2 = rand_bits(5);
		pc = rand_bits(30) << 2;
		imm = rand_bits(32);
	endtask

	task automatic random_alu_fields();
		int kind;
		kind = rand_bits(2) % 3;
		case (kind)
			0: begin
				inst_class = CLASS_ARITH;
				alu_op = alu_op_e'(rand_bits(3) % 5);
			end
			1: begin
				inst_class = CLASS_SHIFT;
				alu_op = alu_op_e'(5 + rand_bits(2) % 3);
			end
			default: begin
				inst_class = CLASS_COMPARE;
				alu_op = alu_op_e'(8 + rand_bits(3) % 6);
			end
		endcase
		op1_sel = operand_sel_e'(rand_bits(3) % 5);
		op2_sel = operand_sel_e'(rand_bits(3) % 5);
		random_regs();
	endtask

	task automatic random_flow_fields();
		random_regs();
		if (rand_bits(1)) begin
			inst_class = CLASS_JUMP;
			alu_op = ALU_ADD;
			if (rand_bits(1))
				op1_sel = SEL_RS1;
			else
				op1_sel = SEL_PC;
			op2_sel = SEL_IMM;
		end else begin
			inst_class = CLASS_BRANCH;
			alu_op = alu_op_e'(8 + rand_bits(3) % 6);
			op1_sel = SEL_RS1;
			op2_sel = SEL_RS2;
			// Equal operands about half the time
			if (rand_bits(1))
				rs2 = rs1;
		end
	endtask

	task automatic load_reg(input int index, input logic [31:0] value);
		random_regs();
		inst_class = CLASS_ARITH;
		alu_op = ALU_ADD;
		op1_sel = SEL_ZERO;
		op2_sel = SEL_IMM;
		rd = index;
		imm = value;
		issue(0, 0);
	endtask

	task automatic muldiv_pair(input logic [31:0] a, input logic [31:0] b);
		load_reg(1, a);
		load_reg(2, b);
		for (int op = 0; op < 7; op++) begin
			random_regs();
			inst_class = CLASS_MULDIV;
			alu_op = ALU_ADD;
			muldiv_op = muldiv_op_e'(op);
			rs1 = 5'd1;
			rs2 = 5'd2;
			rd = 3 + rand_bits(5) % 29;
			issue(0, 0);
		end
	endtask

	// ==============================
	// Comparison
	initial begin
		forever begin
			@(check_event);
			assert (fault == exp_fault)
			else report_error($sformatf("o_fault %b expected %b", fault, exp_fault));
			if (!exp_fault) begin
				assert (result == exp_result)
				else report_error($sformatf("o_result %h expected %h", result, exp_result));
			end
			assert (ret_rd == exp_rd)
			else report_error($sformatf("o_rd %0d expected %0d", ret_rd, exp_rd));
			assert (jump == exp_jump)
			else report_error($sformatf("o_jump %b expected %b", jump, exp_jump));
			if (exp_jump) begin
				assert (jump_pc == exp_jump_pc)
				else report_error($sformatf("o_jump_pc %h expected %h", jump_pc, exp_jump_pc));
			end
			->done_event;
		end
	end

	initial begin
		#(N_INST * 40 * CLOCK_NS);
		$display("Timeout: the execute stage stopped retiring instructions");
		$display("RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		@(negedge reset);
		@(negedge clock);
		assert (ret_tag == 0 && !jump && !fault && result == 0 && !busy)
		else report_error("outputs not cleared by reset");

		for (int i = 0; i < N_RESET_READS; i++) begin
			random_regs();
			inst_class = CLASS_ARITH;
			alu_op = ALU_ADD;
			op1_sel = SEL_RS1;
			op2_sel = SEL_RS2;
			rs2 = '0;
			issue(0, 0);
		end
		for (int i = 1; i <= N_FILL; i++)
			load_reg(i, rand_bits(32));
		for (int i = 0; i < N_FLOW; i++) begin
			random_flow_fields();
			issue(0, 0);
		end
		for (int i = 0; i < N_RANDOM; i++) begin
			random_alu_fields();
			issue(0, 0);
		end

		muldiv_pair(32'h8000_0000, 32'hffff_ffff);
		muldiv_pair(32'h1234_5678, 32'h0000_0000);
		muldiv_pair(32'hffff_fff9, 32'h0000_0003);
		muldiv_pair(32'h8000_0000, 32'h0000_0000);
		for (int i = 4; i < N_MULDIV_PAIRS; i++)
			muldiv_pair(rand_bits(32), rand_bits(32));

		// Back-pressure around acceptance and mid-flight
		for (int i = 0; i < N_HOLD; i++) begin
			if (i % 3 == 2) begin
				random_regs();
				inst_class = CLASS_MULDIV;
				alu_op = ALU_ADD;
				muldiv_op = muldiv_op_e'(rand_bits(3) % 7);
				issue(rand_bits(2), 1 + rand_bits(3) % 7);
			end else begin
				random_alu_fields();
				issue(0, 1 + rand_bits(3) % 7);
			end
		end

		random_alu_fields();
		inst_class = inst_class_e'(3'd6);
		issue(0, 0);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- cpu_execute_unit.f
cpu_pkg.sv
cpu_alu.sv
cpu_multiply.sv
cpu_divide.sv
cpu_register_file.sv
cpu_execute.sv
cpu_execute_unit.sv
tb_clock.sv
tb_cpu_execute_unit.sv

//--- Bender.yml
package:
  name: cpu_execute_unit

sources:
  - cpu_pkg.sv
  - cpu_alu.sv
  - cpu_multiply.sv
  - cpu_divide.sv
  - cpu_register_file.sv
  - cpu_execute.sv
  - cpu_execute_unit.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_cpu_execute_unit.sv
